// File: hw/icache_pkg.sv
`default_nettype none

package icache_pkg;

  ////////////////////////////////////////////////////////////////////////
  // cache geometry
  ////////////////////////////////////////////////////////////////////////
  localparam int ADDR_W         = 20;  // 1 MiB fetch space
  localparam int LINE_BYTES     = 16;
  localparam int OFFSET_W       = $clog2(LINE_BYTES);
  localparam int BEATS_PER_LINE = 4;   // 32-bit memory port
  localparam int BEAT_W         = $clog2(BEATS_PER_LINE);

  ////////////////////////////////////////////////////////////////////////
  // vector types
  ////////////////////////////////////////////////////////////////////////
  typedef logic [ADDR_W-1:0]          fetch_addr_t;   // byte address
  typedef logic [OFFSET_W-1:0]        line_offset_t;  // byte within a line
  typedef logic [BEAT_W-1:0]          beat_t;         // word within a line
  typedef logic [31:0]                instr_t;
  typedef logic [31:0]                mem_word_t;
  typedef logic [LINE_BYTES*8-1:0]    line_t;

  // lookup / refill controller states
  typedef enum logic [1:0] {
    IDLE        = 2'd0,
    LOOKUP      = 2'd1,
    REFILL_MAIN = 2'd2,  // line holding the first byte
    REFILL_NEXT = 2'd3   // following line, for a crossing instruction
  } fsm_state_t;

endpackage

`default_nettype wire

// File: hw/icache_mem_pkg.sv
`default_nettype none

package icache_mem_pkg;

  // read request towards memory
  // addr stays stable while rden is high and no ready has come back
  typedef struct packed {
    logic                    rden;
    icache_pkg::fetch_addr_t addr;  // word aligned
  } mem_req_t;

  // memory answer, ready is a single-cycle pulse
  typedef struct packed {
    logic                  ready;
    icache_pkg::mem_word_t data;
  } mem_rsp_t;

endpackage

`default_nettype wire

// File: hw/icache_fsm.sv
`timescale 1ns/1ps
`default_nettype none

module icache_fsm (
  input  logic i_riscv_icache_clk,
  input  logic i_reset,
  input  logic i_fetch_en,
  input  logic i_hit,         // addressed line present
  input  logic i_hit_next,    // following line present
  input  logic i_need_next,   // instruction crosses into the next line
  input  logic i_beat_last,
  input  logic i_mem_ready,
  output logic o_stall,
  output logic o_mem_rden,
  output logic o_fill_next,
  output logic o_beat_advance,
  output logic o_tag_write
);

  icache_pkg::fsm_state_t state;
  icache_pkg::fsm_state_t state_next;

  logic miss;     // some needed line is absent
  logic accept;   // beat taken this cycle
  logic refill;

  assign miss   = !i_hit || (i_need_next && !i_hit_next);
  assign refill = (state == icache_pkg::REFILL_MAIN) ||
                  (state == icache_pkg::REFILL_NEXT);
  assign accept = refill && i_mem_ready;

  //////////////////////////////////////////////////////////////////////
  // state register
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_riscv_icache_clk) begin
    if (i_reset) begin
      state <= icache_pkg::IDLE;
    end else begin
      state <= state_next;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // next state
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    state_next = state;
    case (state)
      icache_pkg::IDLE: begin
        if (i_fetch_en) begin
          state_next = icache_pkg::LOOKUP;
        end
      end
      icache_pkg::LOOKUP: begin
        if (!i_fetch_en) begin
          state_next = icache_pkg::IDLE;
        end else if (!i_hit) begin
          state_next = icache_pkg::REFILL_MAIN;  // main line first
        end else if (i_need_next && !i_hit_next) begin
          state_next = icache_pkg::REFILL_NEXT;
        end
      end
      icache_pkg::REFILL_MAIN,
      icache_pkg::REFILL_NEXT: begin
        // back to lookup once the whole line is in
        if (accept && i_beat_last) begin
          state_next = icache_pkg::LOOKUP;
        end
      end
      default: state_next = icache_pkg::IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // outputs
  //////////////////////////////////////////////////////////////////////
  always_comb begin
    o_stall        = 1'b0;
    o_mem_rden     = 1'b0;
    o_fill_next    = 1'b0;
    o_beat_advance = 1'b0;
    o_tag_write    = 1'b0;
    case (state)
      icache_pkg::IDLE,
      icache_pkg::LOOKUP: begin
        o_stall = i_fetch_en && miss;  // same-cycle hit answer
      end
      icache_pkg::REFILL_MAIN,
      icache_pkg::REFILL_NEXT: begin
        o_stall        = 1'b1;
        o_mem_rden     = 1'b1;  // held until the last beat is taken
        o_fill_next    = (state == icache_pkg::REFILL_NEXT);
        o_beat_advance = accept;
        o_tag_write    = accept && i_beat_last;
      end
      default: begin
        o_stall = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: hw/icache_beat_counter.sv
`timescale 1ns/1ps
`default_nettype none

module icache_beat_counter (
  input  logic              i_riscv_icache_clk,
  input  logic              i_reset,
  input  logic              i_advance,  // beat accepted
  output icache_pkg::beat_t o_beat,
  output logic              o_last
);

  icache_pkg::beat_t count;

  // last word of the line
  assign o_last = (count == icache_pkg::beat_t'(icache_pkg::BEATS_PER_LINE - 1));
  assign o_beat = count;

  //////////////////////////////////////////////////////////////////////
  // word position within the line being filled
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge i_riscv_icache_clk) begin
    if (i_reset) begin
      count <= '0;
    end else if (i_advance) begin
      if (o_last) begin
        count <= '0;  // ready for the next line
      end else begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

// File: hw/icache_tag_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_tag_array #(
  parameter int INDEX_W = 6
) (
  input  logic                      i_riscv_icache_clk,
  input  logic                      i_reset,
  input  logic [icache_pkg::ADDR_W-icache_pkg::OFFSET_W-INDEX_W-1:0] i_tag,
  input  logic [INDEX_W-1:0]        i_index,
  input  logic [icache_pkg::ADDR_W-icache_pkg::OFFSET_W-INDEX_W-1:0] i_tag_next,
  input  logic [INDEX_W-1:0]        i_index_next,
  input  logic                      i_write,
  input  logic                      i_fill_next,
  output logic                      o_hit,
  output logic                      o_hit_next
);

  localparam int TAG_W = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - INDEX_W;
  localparam int LINES = 2 ** INDEX_W;

  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [INDEX_W-1:0] index_t;

  logic [LINES-1:0] valid;
  tag_t             tags [LINES];

  index_t wr_index;
  tag_t   wr_tag;

  // line being refilled
  assign wr_index = i_fill_next ? i_index_next : i_index;
  assign wr_tag   = i_fill_next ? i_tag_next   : i_tag;

  //////////////////////////////////////////////////////////////////////
  // parallel lookup of both lines
  //////////////////////////////////////////////////////////////////////
  assign o_hit      = valid[i_index]      && (tags[i_index]      == i_tag);
  assign o_hit_next = valid[i_index_next] && (tags[i_index_next] == i_tag_next);

  always_ff @(posedge i_riscv_icache_clk) begin
    if (i_reset) begin
      valid <= '0;
    end else if (i_write) begin
      valid[wr_index] <= 1'b1;
    end
  end

  always_ff @(posedge i_riscv_icache_clk) begin
    if (i_write) begin
      tags[wr_index] <= wr_tag;
    end
  end

endmodule

`default_nettype wire

// File: hw/icache_data_array.sv
`timescale 1ns/1ps
`default_nettype none

module icache_data_array #(
  parameter int INDEX_W = 6
) (
  input  logic                     i_riscv_icache_clk,
  input  logic [INDEX_W-1:0]       i_index,
  input  logic [INDEX_W-1:0]       i_index_next,
  input  icache_pkg::line_offset_t i_offset,
  input  logic                     i_fill_next,
  input  icache_pkg::beat_t        i_beat,
  input  logic                     i_word_we,
  input  icache_pkg::mem_word_t    i_word,
  output icache_pkg::instr_t       o_instr
);

  localparam int LINES = 2 ** INDEX_W;

  typedef logic [INDEX_W-1:0] index_t;

  icache_pkg::line_t lines [LINES];

  index_t            wr_index;
  icache_pkg::line_t line_cur;
  icache_pkg::line_t line_nxt;
  logic [159:0]      window;     // current line plus first word of the next
  logic [6:0]        bit_shift;

  //////////////////////////////////////////////////////////////////////
  // refill, one word per accepted beat
  //////////////////////////////////////////////////////////////////////
  assign wr_index = i_fill_next ? i_index_next : i_index;

  always_ff @(posedge i_riscv_icache_clk) begin
    if (i_word_we) begin
      lines[wr_index][{i_beat, 5'b00000} +: 32] <= i_word;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read both lines and pick 4 bytes at the offset
  //////////////////////////////////////////////////////////////////////
  assign line_cur = lines[i_index];
  assign line_nxt = lines[i_index_next];

  // offsets 13..15 reach into the low bytes of the next line
  assign window    = {line_nxt[31:0], line_cur};
  assign bit_shift = {i_offset, 3'b000};
  assign o_instr   = window[bit_shift +: 32];  // little endian

endmodule

`default_nettype wire

// File: hw/icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int INDEX_W = 6
) (
  input  logic                     i_riscv_icache_clk,
  input  logic                     i_reset,
  input  logic                     i_fetch_en,
  input  icache_pkg::fetch_addr_t  i_fetch_addr,
  input  icache_mem_pkg::mem_rsp_t i_mem_rsp,
  output icache_pkg::instr_t       o_instr,
  output logic                     o_stall,
  output icache_mem_pkg::mem_req_t o_mem_req
);

  localparam int TAG_W  = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - INDEX_W;
  localparam int LADDR_W = TAG_W + INDEX_W;

  typedef logic [TAG_W-1:0]   tag_t;
  typedef logic [INDEX_W-1:0] index_t;
  typedef logic [LADDR_W-1:0] line_addr_t;  // tag and index together

  //////////////////////////////////////////////////////////////////////
  // address split
  //////////////////////////////////////////////////////////////////////
  tag_t                     tag;
  index_t                   index;
  icache_pkg::line_offset_t offset;
  line_addr_t               line_addr;
  line_addr_t               line_addr_next;
  tag_t                     tag_next;
  index_t                   index_next;
  line_addr_t               fill_line;

  // control
  logic              hit;
  logic              hit_next;
  logic              need_next;
  logic              beat_last;
  logic              beat_advance;
  logic              fill_next;
  logic              tag_write;
  logic              mem_rden;
  icache_pkg::beat_t beat;

  assign {tag, index, offset} = i_fetch_addr;
  assign line_addr            = {tag, index};
  assign line_addr_next       = line_addr + 1'b1;  // wraps at the top of memory
  assign {tag_next, index_next} = line_addr_next;

  // bytes past offset 12 live in the next line
  assign need_next = offset >
                     icache_pkg::line_offset_t'(icache_pkg::LINE_BYTES - 4);

  //////////////////////////////////////////////////////////////////////
  // refill request
  //////////////////////////////////////////////////////////////////////
  assign fill_line      = fill_next ? line_addr_next : line_addr;
  assign o_mem_req.rden = mem_rden;
  assign o_mem_req.addr = {fill_line, beat, 2'b00};

  icache_fsm u_icache_fsm (
    .i_riscv_icache_clk ( i_riscv_icache_clk ),
    .i_reset            ( i_reset            ),
    .i_fetch_en         ( i_fetch_en         ),
    .i_hit              ( hit                ),
    .i_hit_next         ( hit_next           ),
    .i_need_next        ( need_next          ),
    .i_beat_last        ( beat_last          ),
    .i_mem_ready        ( i_mem_rsp.ready    ),
    .o_stall            ( o_stall            ),
    .o_mem_rden         ( mem_rden           ),
    .o_fill_next        ( fill_next          ),
    .o_beat_advance     ( beat_advance       ),
    .o_tag_write        ( tag_write          )
  );

  icache_beat_counter u_icache_beat_counter (
    .i_riscv_icache_clk ( i_riscv_icache_clk ),
    .i_reset            ( i_reset            ),
    .i_advance          ( beat_advance       ),
    .o_beat             ( beat               ),
    .o_last             ( beat_last          )
  );

  icache_tag_array #(
    .INDEX_W ( INDEX_W )
  ) u_icache_tag_array (
    .i_riscv_icache_clk ( i_riscv_icache_clk ),
    .i_reset            ( i_reset            ),
    .i_tag              ( tag                ),
    .i_index            ( index              ),
    .i_tag_next         ( tag_next           ),
    .i_index_next       ( index_next         ),
    .i_write            ( tag_write          ),
    .i_fill_next        ( fill_next          ),
    .o_hit              ( hit                ),
    .o_hit_next         ( hit_next           )
  );

  icache_data_array #(
    .INDEX_W ( INDEX_W )
  ) u_icache_data_array (
    .i_riscv_icache_clk ( i_riscv_icache_clk ),
    .i_index            ( index              ),
    .i_index_next       ( index_next         ),
    .i_offset           ( offset             ),
    .i_fill_next        ( fill_next          ),
    .i_beat             ( beat               ),
    .i_word_we          ( beat_advance       ),  // accepted beat
    .i_word             ( i_mem_rsp.data     ),
    .o_instr            ( o_instr            )
  );

endmodule

`default_nettype wire

// File: verif/icache_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model #(
  parameter logic [31:0] SEED = 32'h3583_e3a8
) (
  input  logic                     i_clk,
  input  logic                     i_reset,
  input  logic                     i_rand_delay,  // back-pressure on
  input  icache_mem_pkg::mem_req_t i_mem_req,
  output icache_mem_pkg::mem_rsp_t o_mem_rsp,
  output int                       o_beats        // accepted beats since time 0
);

  integer                seed       = SEED;
  logic                  ready      = 1'b0;
  icache_pkg::mem_word_t data       = '0;
  logic                  pending    = 1'b0;  // request seen, delay running
  logic [2:0]            wait_cnt   = '0;
  int                    beat_count = 0;

  assign o_mem_rsp.ready = ready;
  assign o_mem_rsp.data  = data;
  assign o_beats         = beat_count;

  function automatic logic [7:0] byte_at(icache_pkg::fetch_addr_t a);
    return 8'(a * 20'h9d) ^ 8'(a >> 8);
  endfunction

  // little endian word from four bytes
  function automatic icache_pkg::mem_word_t word_at(icache_pkg::fetch_addr_t a);
    icache_pkg::mem_word_t w;
    for (int i = 0; i < 4; i++) begin
      w[8*i +: 8] = byte_at(a + icache_pkg::fetch_addr_t'(i));
    end
    return w;
  endfunction

  always @(posedge i_clk) begin
    logic [31:0] rnd;
    if (i_reset) begin
      ready   <= 1'b0;
      pending <= 1'b0;
    end else if (ready) begin
      ready   <= 1'b0;  // single-cycle pulse
      pending <= 1'b0;
      if (i_mem_req.rden) begin
        beat_count <= beat_count + 1;
      end
    end else if (pending) begin
      if (wait_cnt == 3'd0) begin
        ready <= 1'b1;
        data  <= word_at(i_mem_req.addr);
      end else begin
        wait_cnt <= wait_cnt - 3'd1;
      end
    end else if (i_mem_req.rden) begin
      rnd      = $random(seed);
      pending  <= 1'b1;
      wait_cnt <= i_rand_delay ? rnd[2:0] : 3'd0;
    end
  end

endmodule

`default_nettype wire

// File: verif/tb_icache_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_icache_top;

  localparam int          INDEX_W     = 6;
  localparam int          LINES       = 2 ** INDEX_W;
  localparam int          TAG_W       = icache_pkg::ADDR_W - icache_pkg::OFFSET_W - INDEX_W;
  localparam int          LADDR_W     = TAG_W + INDEX_W;
  localparam logic [31:0] RAND_SEED   = 32'h3583_e3a8;
  localparam int          N_RANDOM    = 40;
  localparam int          N_FETCH     = 2 + 13 + 6 + 4 + 2 + N_RANDOM;
  localparam int          FETCH_LIMIT = 150;  // cycles before a fetch counts as hung

  logic                     clk;
  logic                     reset;
  logic                     fetch_en;
  icache_pkg::fetch_addr_t  fetch_addr;
  icache_pkg::instr_t       instr;
  logic                     stall;
  icache_mem_pkg::mem_req_t mem_req;
  icache_mem_pkg::mem_rsp_t mem_rsp;
  logic                     rand_delay;
  int                       mem_beats;

  integer seed          = RAND_SEED;
  int     err_count     = 0;
  int     timeout_count = 0;
  int     n_checks      = 0;

  logic             mir_valid [LINES];  // mirror of the tag array
  logic [TAG_W-1:0] mir_tag   [LINES];

  icache_top #(.INDEX_W(INDEX_W)) icache_top_i (
    .i_riscv_icache_clk ( clk        ),
    .i_reset            ( reset      ),
    .i_fetch_en         ( fetch_en   ),
    .i_fetch_addr       ( fetch_addr ),
    .i_mem_rsp          ( mem_rsp    ),
    .o_instr            ( instr      ),
    .o_stall            ( stall      ),
    .o_mem_req          ( mem_req    )
  );

  icache_mem_model #(.SEED(RAND_SEED)) mem_model_i (
    .i_clk        ( clk        ),
    .i_reset      ( reset      ),
    .i_rand_delay ( rand_delay ),
    .i_mem_req    ( mem_req    ),
    .o_mem_rsp    ( mem_rsp    ),
    .o_beats      ( mem_beats  )
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // reference model
  //////////////////////////////////////////////////////////////////////
  function automatic logic [7:0] byte_value(icache_pkg::fetch_addr_t a);
    return 8'(a * 20'h9d) ^ 8'(a >> 8);
  endfunction

  function automatic icache_pkg::instr_t expected_instr(icache_pkg::fetch_addr_t a);
    icache_pkg::instr_t w;
    for (int i = 0; i < 4; i++) begin
      w[8*i +: 8] = byte_value(a + icache_pkg::fetch_addr_t'(i));  // little endian
    end
    return w;
  endfunction

  function automatic logic line_present(logic [LADDR_W-1:0] la);
    return mir_valid[la[INDEX_W-1:0]] && (mir_tag[la[INDEX_W-1:0]] == la[LADDR_W-1:INDEX_W]);
  endfunction

  // lines a fetch must bring in, the next one only past byte 12
  function automatic int lines_to_refill(icache_pkg::fetch_addr_t a);
    logic [LADDR_W-1:0] la;
    int                 n;
    la = a[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W];
    n  = line_present(la) ? 0 : 1;
    if (a[3:0] > 4'd12 && !line_present(la + LADDR_W'(1))) begin
      n++;
    end
    return n;
  endfunction

  task automatic mark_line(logic [LADDR_W-1:0] la);
    mir_valid[la[INDEX_W-1:0]] = 1'b1;
    mir_tag[la[INDEX_W-1:0]]   = la[LADDR_W-1:INDEX_W];
  endtask

  task automatic mirror_clear();
    for (int i = 0; i < LINES; i++) begin
      mir_valid[i] = 1'b0;
      mir_tag[i]   = '0;
    end
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("Fail %s: got 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
    end
  endtask

  task automatic apply_reset();
    @(negedge clk);
    reset    = 1'b1;
    fetch_en = 1'b0;
    repeat (10) @(negedge clk);
    reset = 1'b0;
    mirror_clear();
  endtask

  // one fetch, held until the cache stops stalling
  task automatic fetch(icache_pkg::fetch_addr_t a);
    int beats_before;
    int exp_beats;
    int cycles;
    exp_beats    = icache_pkg::BEATS_PER_LINE * lines_to_refill(a);
    beats_before = mem_beats;
    @(negedge clk);
    fetch_en   = 1'b1;
    fetch_addr = a;
    cycles     = 0;
    @(posedge clk);
    check_value("o_stall", stall, exp_beats != 0);  // raised in the miss cycle only
    while (stall && cycles < FETCH_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    if (stall) begin
      timeout_count++;
      $display("fetch of address 0x%05h still stalled after %0d cycles", a, FETCH_LIMIT);
    end else begin
      check_value("mem beats", mem_beats - beats_before, exp_beats);
    end
    mark_line(a[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W]);
    if (a[3:0] > 4'd12) begin
      mark_line(a[icache_pkg::ADDR_W-1:icache_pkg::OFFSET_W] + LADDR_W'(1));
    end
    @(negedge clk);
    fetch_en = 1'b0;
  endtask

  // every delivered instruction against the reference
  always @(posedge clk) begin
    if (!reset && fetch_en && !stall) begin
      check_value("o_instr", instr, expected_instr(fetch_addr));
      n_checks++;
    end else if (!reset && !fetch_en) begin
      check_value("o_stall", stall, 1'b0);  // idle core
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////
  initial begin
    icache_pkg::fetch_addr_t a;
    logic [31:0]             r;
    reset      = 1'b1;
    fetch_en   = 1'b0;
    fetch_addr = '0;
    rand_delay = 1'b0;
    mirror_clear();
    apply_reset();
    fetch(20'h00400);  // cold miss
    fetch(20'h00400);
    for (int o = 0; o <= 12; o++) begin
      fetch(20'h00400 + icache_pkg::fetch_addr_t'(o));
    end
    for (int pass = 0; pass < 2; pass++) begin  // both lines absent, then both present
      for (int k = 0; k < 3; k++) begin
        a = 20'h00520 + icache_pkg::fetch_addr_t'(k * 64 + 13 + k);
        fetch(a);
      end
    end
    for (int k = 0; k < 4; k++) begin
      fetch((k % 2 == 1) ? 20'h00e80 : 20'h00a80);  // same index, tags 2 and 3
    end
    apply_reset();
    fetch(20'h00400);
    fetch(20'h0040e);  // next line gone since the reset
    rand_delay = 1'b1;
    for (int n = 0; n < N_RANDOM; n++) begin
      r = $random(seed);
      fetch(icache_pkg::fetch_addr_t'(r[10:0]));
    end
    check_value("fetch checks", n_checks, N_FETCH);
    $display("errors: %0d value, %0d timeout; %0d fetches checked",
             err_count, timeout_count, n_checks);
    if (err_count == 0 && timeout_count == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

  initial begin
    repeat (N_FETCH * 200) @(posedge clk);
    $display("watchdog expired after %0d cycles with %0d value errors and %0d fetches checked",
             N_FETCH * 200, err_count, n_checks);
    $display("=== FAIL ===");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
hw/icache_pkg.sv
hw/icache_mem_pkg.sv
hw/icache_fsm.sv
hw/icache_beat_counter.sv
hw/icache_tag_array.sv
hw/icache_data_array.sv
hw/icache_top.sv
verif/icache_mem_model.sv
verif/tb_icache_top.sv

// File: Makefile
VERILATOR  ?= verilator
FLIST      ?= flist.f
TB_TOP     ?= tb_icache_top
RTL_TOP    ?= icache_top
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing -Wall
SIM_FLAGS  ?= --binary --timing -Wno-fatal

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FLIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -Mdir $(BUILD_DIR) -f $(FLIST)

sim: build
	./$(BUILD_DIR)/V$(TB_TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "=== FAIL ===" $(LOG); then echo "simulation failed, see $(LOG)"; exit 1; fi
	@grep -q "=== PASS ===" $(LOG) || { echo "no result found in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
